// ==== bench/tb_sprite_mapper.sv ====
`timescale 1ns/1ps

module tb_sprite_mapper;
    import video_geom_pkg::*;
    import sprite_pkg::*;

    localparam int W_TAB [5] = '{80, 96, 80, 128, 102};   // stand fwd back punch kick
    localparam int H_TAB [5] = '{112, 112, 112, 96, 112};
    localparam int F_TAB [5] = '{6, 4, 4, 4, 5};
    localparam int TICKS = 7;
    localparam color_t KEY = 12'hF0F;                    // Magenta, see-through

    logic          vsync;
    logic          reset;
    logic          forward, back, punch, kick;
    logic          blank;
    world_coord_t  fighter_x, fighter_y, scroll_x;
    screen_coord_t draw_x, draw_y;
    color_t        sprite_pixel, backdrop_pixel;
    pose_t         sprite_pose;
    rom_addr_t     sprite_addr, backdrop_addr;
    channel_t      red, green, blue;

    logic [31:0] rng;
    pose_t       m_pose;        // Reference model state
    logic        m_restart;
    int          m_tick;
    int          m_frame;
    int          mismatches;
    int          timeouts;

    sprite_mapper i_dut (.*);

    always #20 vsync = ~vsync;

    // ------------------------------------------------------------------------
    // ROM models and random numbers
    // ------------------------------------------------------------------------

    function automatic color_t sprite_rom(input pose_t p, input rom_addr_t a);
        logic [31:0] h;
        h = 32'({a, p}) * 32'h9E3779B1;
        return (h[29:28] == 2'b00) ? KEY : h[27:16];   // About one in four is key
    endfunction

    function automatic color_t backdrop_rom(input rom_addr_t a);
        logic [31:0] h;
        h = 32'(a) * 32'h9E3779B1;
        return h[29:18];
    endfunction

    always_comb begin
        sprite_pixel   = sprite_rom(sprite_pose, sprite_addr);
        backdrop_pixel = backdrop_rom(backdrop_addr);
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_below(input int n);
        rng = lcg_next(rng);
        return int'(rng[30:8]) % n;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    task automatic model_edge;
        int    last_f;
        logic  done;
        pose_t nxt;
        last_f = F_TAB[m_pose] - 1;
        done   = !m_restart && m_frame == last_f && m_tick == TICKS - 1;
        if ((m_pose == POSE_PUNCH || m_pose == POSE_KICK) && !done) nxt = m_pose;
        else if (forward) nxt = POSE_FORWARD;
        else if (back)    nxt = POSE_BACK;
        else if (punch)   nxt = POSE_PUNCH;
        else if (kick)    nxt = POSE_KICK;
        else              nxt = POSE_STAND;
        if (m_restart) begin
            m_tick  = 0;
            m_frame = 0;
        end else if (m_tick == TICKS - 1) begin
            m_tick  = 0;
            m_frame = (m_frame >= last_f) ? 0 : m_frame + 1;
        end else begin
            m_tick++;
        end
        m_restart = (nxt != m_pose);
        m_pose    = nxt;
    endtask

    task automatic sprite_model(output logic hit, output rom_addr_t addr);
        int w;
        int h;
        int ox;
        int oy;
        w  = W_TAB[m_pose];
        h  = H_TAB[m_pose];
        ox = int'(draw_x) - (int'(fighter_x) - int'(scroll_x));
        oy = int'(draw_y) - (int'(fighter_y) + 2 * (112 - h));   // Bottom aligned box
        hit  = ox >= 0 && ox < 2 * w && oy >= 0 && oy < 2 * h;
        addr = hit ? rom_addr_t'(w * (oy / 2) + ox / 2 + m_frame * w * h) : '0;
    endtask

    function automatic rom_addr_t backdrop_model(input int dx, input int dy, input int sx);
        int n;
        int col;
        n   = (dx + sx) / 2;
        col = (n >= 321 && n < 512) ? 190 - (n - 321) : n % 191;
        return rom_addr_t'((dy / 2) * 191 + col);
    endfunction

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    task automatic check_pose(input string name, input pose_t got, input pose_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_pixel;
        logic      hit;
        rom_addr_t s_addr;
        rom_addr_t b_addr;
        color_t    s_pix;
        color_t    exp;
        sprite_model(hit, s_addr);
        b_addr = backdrop_model(int'(draw_x), int'(draw_y), int'(scroll_x));
        s_pix  = sprite_rom(m_pose, s_addr);
        if (blank) exp = '0;
        else if (hit && s_pix != KEY) exp = s_pix;
        else exp = backdrop_rom(b_addr);
        check_addr("sprite_addr", sprite_addr, s_addr);
        check_addr("backdrop_addr", backdrop_addr, b_addr);
        check_color("rgb", {red, green, blue}, exp);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // One vsync period: new buttons and position, then 20 random pixels
    task automatic run_frame(input logic [3:0] btn);
        int left;
        int top;
        @(posedge vsync);
        model_edge();
        #2;
        {forward, back, punch, kick} = btn;
        scroll_x  = world_coord_t'(rand_below(2048));
        fighter_x = world_coord_t'(int'(scroll_x) + rand_below(560));
        fighter_y = world_coord_t'(rand_below(240));
        check_pose("sprite_pose", sprite_pose, m_pose);
        left = int'(fighter_x) - int'(scroll_x);
        top  = int'(fighter_y) + 2 * (112 - H_TAB[m_pose]);
        for (int i = 0; i < 20; i++) begin
            if (rand_below(2) == 0) begin            // Near the fighter box
                draw_x = screen_coord_t'(left + rand_below(2 * W_TAB[m_pose] + 8) - 4);
                draw_y = screen_coord_t'(top + rand_below(2 * H_TAB[m_pose] + 8) - 4);
            end else begin
                draw_x = screen_coord_t'(rand_below(640));
                draw_y = screen_coord_t'(rand_below(480));
            end
            blank = (rand_below(8) == 0);
            #0.75;
            check_pixel();
            #0.75;
        end
    endtask

    task automatic wait_pose(input pose_t target, input logic [3:0] btn, input int limit);
        int n;
        n = 0;
        while (sprite_pose !== target && n < limit) begin
            run_frame(btn);
            n++;
        end
        if (sprite_pose !== target) begin
            timeouts++;
            $display("Timeout: pose %0d not reached within %0d frames", target, limit);
        end
    endtask

    initial begin
        logic [3:0] btn;
        vsync = 1'b0;
        reset = 1'b1;
        {forward, back, punch, kick} = 4'b0000;
        blank     = 1'b0;
        fighter_x = '0;
        fighter_y = '0;
        scroll_x  = '0;
        draw_x    = '0;
        draw_y    = '0;
        rng        = 32'd11;
        m_pose     = POSE_STAND;
        m_restart  = 1'b0;
        m_tick     = 0;
        m_frame    = 0;
        mismatches = 0;
        timeouts   = 0;
        repeat (10) @(posedge vsync);
        #2 reset = 1'b0;

        // Top-left pixel of the standing box, frame 0
        fighter_x = 11'd100;
        fighter_y = 11'd60;
        scroll_x  = 11'd20;
        draw_x    = 10'd80;
        draw_y    = 10'd60;
        #1;
        check_pose("sprite_pose", sprite_pose, POSE_STAND);
        check_pixel();

        // One native pixel in from the corner, row 1 column 1
        draw_x = 10'd82;
        draw_y = 10'd62;
        #1;
        check_pixel();

        // Short presses, attacks must play to the end
        wait_pose(POSE_PUNCH, 4'b0010, 4);
        wait_pose(POSE_STAND, 4'b0000, 40);
        wait_pose(POSE_KICK, 4'b0001, 4);
        wait_pose(POSE_STAND, 4'b0000, 40);

        btn = 4'b0000;
        for (int f = 0; f < 300; f++) begin
            if (rand_below(6) == 0) begin             // Mostly long holds
                if (rand_below(2) == 0) btn = 4'b1000 >> rand_below(5);
                else btn = 4'(rand_below(16));
            end
            run_frame(btn);
        end

        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/anim_counter.sv ====
`timescale 1ns/1ps

module anim_counter (
    input  logic               vsync,
    input  logic               reset,
    input  sprite_pkg::pose_t  pose,
    input  logic               pose_restart,
    output sprite_pkg::frame_t frame,
    output logic               anim_done
);
    import sprite_pkg::*;

    tick_t  tick;
    frame_t last_frame;

    assign last_frame = frame_t'(POSE_FRAMES[pose] - 1);

    always_ff @(posedge vsync or posedge reset) begin
        if (reset) begin
            tick  <= '0;
            frame <= '0;
        end else if (pose_restart) begin
            tick  <= '0;
            frame <= '0;
        end else if (tick == tick_t'(TICKS_PER_FRAME - 1)) begin
            tick <= '0;
            if (frame >= last_frame) begin
                frame <= '0;                    // Loop the animation
            end else begin
                frame <= frame + 1'b1;
            end
        end else begin
            tick <= tick + 1'b1;
        end
    end

    // Counters still belong to the old pose until the restart edge
    assign anim_done = !pose_restart && (frame == last_frame)
                     && (tick == tick_t'(TICKS_PER_FRAME - 1));

    a_frame_in_range: assert property (@(posedge vsync) disable iff (reset)
        !pose_restart |-> (int'(frame) < POSE_FRAMES[pose]));

endmodule

// ==== rtl/backdrop_addr.sv ====
`timescale 1ns/1ps

module backdrop_addr (
    input  video_geom_pkg::screen_coord_t draw_x,
    input  video_geom_pkg::screen_coord_t draw_y,
    input  video_geom_pkg::world_coord_t  scroll_x,
    output sprite_pkg::rom_addr_t         backdrop_addr
);
    import video_geom_pkg::*;
    import sprite_pkg::*;

    logic [11:0]   world_x;
    logic [10:0]   column;     // Native world column
    native_coord_t src_col;
    native_coord_t row;

    always_comb begin
        world_x = {2'b00, draw_x} + {1'b0, scroll_x};
        column  = 11'(world_x / PIXEL_SCALE);

        if (column >= 11'(BACKDROP_MIRROR_START) && column < 11'(BACKDROP_MIRROR_END)) begin
            src_col = native_coord_t'(BACKDROP_WIDTH - 1
                                      - (int'(column) - BACKDROP_MIRROR_START));
        end else begin
            src_col = native_coord_t'(column % 11'(BACKDROP_WIDTH));   // Tile repeats
        end

        row = native_coord_t'(draw_y / PIXEL_SCALE);
        backdrop_addr = rom_addr_t'(row) * rom_addr_t'(BACKDROP_WIDTH) + rom_addr_t'(src_col);
    end

endmodule

// ==== rtl/pixel_compositor.sv ====
`timescale 1ns/1ps

module pixel_compositor (
    input  logic                 blank,
    input  logic                 sprite_hit,
    input  sprite_pkg::color_t   sprite_pixel,
    input  sprite_pkg::color_t   backdrop_pixel,
    output sprite_pkg::channel_t red,
    output sprite_pkg::channel_t green,
    output sprite_pkg::channel_t blue
);
    import sprite_pkg::*;

    color_t shown;

    always_comb begin
        if (blank) begin
            shown = '0;                         // Black outside active video
        end else if (sprite_hit && sprite_pixel != KEY_COLOR) begin
            shown = sprite_pixel;               // Fighter in front of backdrop
        end else begin
            shown = backdrop_pixel;
        end
    end

    assign red   = shown[11:8];
    assign green = shown[7:4];
    assign blue  = shown[3:0];

    always_comb begin
        if (blank) begin
            a_blank_black: assert ({red, green, blue} == 12'h000);
        end
    end

endmodule

// ==== rtl/pose_fsm.sv ====
`timescale 1ns/1ps

module pose_fsm (
    input  logic              vsync,
    input  logic              reset,
    input  logic              forward,
    input  logic              back,
    input  logic              punch,
    input  logic              kick,
    input  logic              anim_done,
    output sprite_pkg::pose_t pose,
    output logic              pose_restart
);
    import sprite_pkg::*;

    pose_t pose_next;
    logic  attacking;

    assign attacking = (pose == POSE_PUNCH) || (pose == POSE_KICK);

    always_comb begin
        if (attacking && !anim_done) begin
            pose_next = pose;                   // Attack plays to the end
        end else if (forward) begin
            pose_next = POSE_FORWARD;
        end else if (back) begin
            pose_next = POSE_BACK;
        end else if (punch) begin
            pose_next = POSE_PUNCH;
        end else if (kick) begin
            pose_next = POSE_KICK;
        end else begin
            pose_next = POSE_STAND;
        end
    end

    always_ff @(posedge vsync or posedge reset) begin
        if (reset) begin
            pose         <= POSE_STAND;
            pose_restart <= 1'b0;
        end else begin
            pose         <= pose_next;
            pose_restart <= (pose_next != pose);   // One frame flag to restart animation
        end
    end

    // An unfinished punch or kick cannot be interrupted by any button
    a_attack_commit: assert property (@(posedge vsync) disable iff (reset)
        ((pose == POSE_PUNCH || pose == POSE_KICK) && !anim_done) |=> $stable(pose));

endmodule

// ==== rtl/sprite_mapper.sv ====
`timescale 1ns/1ps

module sprite_mapper (
    input  logic                          vsync,
    input  logic                          reset,
    input  logic                          forward,
    input  logic                          back,
    input  logic                          punch,
    input  logic                          kick,
    input  video_geom_pkg::world_coord_t  fighter_x,
    input  video_geom_pkg::world_coord_t  fighter_y,
    input  video_geom_pkg::world_coord_t  scroll_x,
    input  video_geom_pkg::screen_coord_t draw_x,
    input  video_geom_pkg::screen_coord_t draw_y,
    input  logic                          blank,
    input  sprite_pkg::color_t            sprite_pixel,
    input  sprite_pkg::color_t            backdrop_pixel,
    output sprite_pkg::pose_t             sprite_pose,
    output sprite_pkg::rom_addr_t         sprite_addr,
    output sprite_pkg::rom_addr_t         backdrop_addr,
    output sprite_pkg::channel_t          red,
    output sprite_pkg::channel_t          green,
    output sprite_pkg::channel_t          blue
);
    import sprite_pkg::*;

    logic   pose_restart;
    logic   anim_done;
    logic   sprite_hit;
    frame_t frame;

    // ------------------------------------------------------------------------
    // Frame path, advances once per vsync
    // ------------------------------------------------------------------------

    pose_fsm i_pose_fsm (
        .vsync        (vsync),
        .reset        (reset),
        .forward      (forward),
        .back         (back),
        .punch        (punch),
        .kick         (kick),
        .anim_done    (anim_done),
        .pose         (sprite_pose),
        .pose_restart (pose_restart)
    );

    anim_counter i_anim_counter (
        .vsync        (vsync),
        .reset        (reset),
        .pose         (sprite_pose),
        .pose_restart (pose_restart),
        .frame        (frame),
        .anim_done    (anim_done)
    );

    // ------------------------------------------------------------------------
    // Pixel path, combinational from draw position to colour
    // ------------------------------------------------------------------------

    sprite_window i_sprite_window (
        .draw_x      (draw_x),
        .draw_y      (draw_y),
        .fighter_x   (fighter_x),
        .fighter_y   (fighter_y),
        .scroll_x    (scroll_x),
        .pose        (sprite_pose),
        .frame       (frame),
        .sprite_hit  (sprite_hit),
        .sprite_addr (sprite_addr)
    );

    backdrop_addr i_backdrop_addr (
        .draw_x        (draw_x),
        .draw_y        (draw_y),
        .scroll_x      (scroll_x),
        .backdrop_addr (backdrop_addr)
    );

    pixel_compositor i_pixel_compositor (
        .blank          (blank),
        .sprite_hit     (sprite_hit),
        .sprite_pixel   (sprite_pixel),
        .backdrop_pixel (backdrop_pixel),
        .red            (red),
        .green          (green),
        .blue           (blue)
    );

endmodule

// ==== rtl/sprite_pkg.sv ====
package sprite_pkg;

    // ------------------------------------------------------------------------
    // Fighter state and counters
    // ------------------------------------------------------------------------

    typedef enum logic [2:0] {
        POSE_STAND   = 3'd0,
        POSE_FORWARD = 3'd1,
        POSE_BACK    = 3'd2,
        POSE_PUNCH   = 3'd3,
        POSE_KICK    = 3'd4
    } pose_t;

    typedef logic [2:0]  frame_t;      // Animation frame index
    typedef logic [2:0]  tick_t;       // Vsync periods inside one frame
    typedef logic [17:0] rom_addr_t;   // Sprite or backdrop ROM word
    typedef logic [3:0]  channel_t;
    typedef logic [11:0] color_t;      // R in [11:8], G in [7:4], B in [3:0]

    localparam int TICKS_PER_FRAME = 7;
    localparam int STAND_HEIGHT    = 112;   // Native height of the upright box

    // Magenta marks see-through sprite pixels
    localparam color_t KEY_COLOR = 12'hF0F;

    // ------------------------------------------------------------------------
    // Per-pose art tables, indexed by pose_t
    // ------------------------------------------------------------------------

    //                               stand fwd back punch kick
    localparam int POSE_WIDTH  [5] = '{80,  96,  80,  128,  102};
    localparam int POSE_HEIGHT [5] = '{112, 112, 112, 96,   112};
    localparam int POSE_FRAMES [5] = '{6,   4,   4,   4,    5};

endpackage

// ==== rtl/sprite_window.sv ====
`timescale 1ns/1ps

module sprite_window (
    input  video_geom_pkg::screen_coord_t draw_x,
    input  video_geom_pkg::screen_coord_t draw_y,
    input  video_geom_pkg::world_coord_t  fighter_x,
    input  video_geom_pkg::world_coord_t  fighter_y,
    input  video_geom_pkg::world_coord_t  scroll_x,
    input  sprite_pkg::pose_t             pose,
    input  sprite_pkg::frame_t            frame,
    output logic                          sprite_hit,
    output sprite_pkg::rom_addr_t         sprite_addr
);
    import video_geom_pkg::*;
    import sprite_pkg::*;

    logic [7:0]         width;
    logic [7:0]         height;
    logic signed [12:0] box_left;
    logic signed [12:0] box_top;
    logic signed [12:0] off_x;
    logic signed [12:0] off_y;
    logic               in_x;
    logic               in_y;
    native_coord_t      col;
    native_coord_t      row;
    rom_addr_t          frame_base;

    // ------------------------------------------------------------------------
    // Box position
    // ------------------------------------------------------------------------

    always_comb begin
        width  = 8'(POSE_WIDTH[pose]);
        height = 8'(POSE_HEIGHT[pose]);

        box_left = $signed({2'b00, fighter_x}) - $signed({2'b00, scroll_x});
        // Short poses sit on the same floor line as the standing box
        box_top  = $signed({2'b00, fighter_y})
                 + 13'(PIXEL_SCALE * (STAND_HEIGHT - int'(height)));

        off_x = $signed({3'b000, draw_x}) - box_left;
        off_y = $signed({3'b000, draw_y}) - box_top;
    end

    // ------------------------------------------------------------------------
    // Hit test and ROM address
    // ------------------------------------------------------------------------

    always_comb begin
        in_x = (off_x >= 0) && (off_x < $signed(13'(PIXEL_SCALE * int'(width))));
        in_y = (off_y >= 0) && (off_y < $signed(13'(PIXEL_SCALE * int'(height))));
        sprite_hit = in_x && in_y;

        col = native_coord_t'(off_x / PIXEL_SCALE);   // Native pixel inside the box
        row = native_coord_t'(off_y / PIXEL_SCALE);

        // Frames are stored back to back in the pose's ROM
        frame_base = rom_addr_t'(frame) * rom_addr_t'(width) * rom_addr_t'(height);

        if (sprite_hit) begin
            sprite_addr = rom_addr_t'(width) * rom_addr_t'(row) + rom_addr_t'(col)
                        + frame_base;
        end else begin
            sprite_addr = '0;
        end
    end

endmodule

// ==== rtl/video_geom_pkg.sv ====
package video_geom_pkg;

    // ------------------------------------------------------------------------
    // Coordinate types
    // ------------------------------------------------------------------------

    typedef logic [9:0]  screen_coord_t;    // Visible pixel position
    typedef logic [10:0] world_coord_t;     // Fighter position and scroll offset
    typedef logic [9:0]  native_coord_t;    // ROM pixel, screen coordinate halved

    // ------------------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------------------

    // Every ROM pixel is drawn as a 2x2 block on screen
    localparam int PIXEL_SCALE = 2;

    localparam int BACKDROP_WIDTH        = 191;    // Native columns in backdrop art
    localparam int BACKDROP_MIRROR_START = 321;    // First mirrored world column
    localparam int BACKDROP_MIRROR_END   = 512;    // End of mirrored stretch

endpackage

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sprite_mapper \
    -f sprite_mapper.f -o tb_sprite_mapper > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sprite_mapper > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== sprite_mapper.f ====
rtl/video_geom_pkg.sv
rtl/sprite_pkg.sv
rtl/pose_fsm.sv
rtl/anim_counter.sv
rtl/sprite_window.sv
rtl/backdrop_addr.sv
rtl/pixel_compositor.sv
rtl/sprite_mapper.sv
bench/tb_sprite_mapper.sv
